//--- design/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// ----------------------------------------------------------------------
// Bus geometry
// ----------------------------------------------------------------------
// Byte address and bus word
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Byte lanes per word and bits of a byte offset within a word
`define DMA_STRB_WIDTH 4
`define DMA_OFFS_WIDTH 2

// ----------------------------------------------------------------------
// Transfer and buffer sizing
// ----------------------------------------------------------------------
// Transfer length in bytes
`define DMA_LEN_WIDTH 16
// Entries per byte-lane FIFO
`define DMA_LANE_DEPTH 4

`endif

//--- design/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

    // Byte address and bus word
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
    // A single byte held in one lane
    typedef logic [7:0] byte_t;
    // Lane mask or byte enable
    typedef logic [`DMA_STRB_WIDTH-1:0] strb_t;
    // Offset, tailer or shift within a word
    typedef logic [`DMA_OFFS_WIDTH-1:0] offs_t;
    // Byte count, also used for beat counters
    typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

    // Transfer control FSM
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE
    } ctrl_state_e;

    // First/last lane mask of a beat
    // Lanes from offset upward, cut above the tailer
    // Tailer of zero keeps all lanes up to the top
    function automatic strb_t lane_mask(input offs_t offset, input offs_t tailer);
        strb_t head;
        strb_t tail;
        head = {`DMA_STRB_WIDTH{1'b1}} << offset;
        tail = {`DMA_STRB_WIDTH{1'b1}};
        if (tailer != '0) begin
            tail = {`DMA_STRB_WIDTH{1'b1}} >> (`DMA_STRB_WIDTH - tailer);
        end
        return head & tail;
    endfunction

endpackage

//--- design/dma_transfer_ctrl.sv
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_transfer_ctrl (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  dma_pkg::addr_t     src_addr_i,
    input  dma_pkg::addr_t     dst_addr_i,
    input  dma_pkg::len_t      length_i,
    input  logic               rd_gnt_i,
    input  logic               r_dp_ready_i,
    input  logic               w_dp_ready_i,
    input  logic               wr_beat_done_i,
    input  logic               rd_err_seen_i,
    input  logic               wr_err_seen_i,
    output logic               busy_o,
    output logic               done_o,
    output logic               err_o,
    output logic               rd_req_o,
    output dma_pkg::addr_t     rd_addr_o,
    output logic               r_dp_valid_o,
    output dma_pkg::offs_t     r_dp_offset_o,
    output dma_pkg::offs_t     r_dp_tailer_o,
    output dma_pkg::offs_t     r_dp_shift_o,
    output logic               w_dp_valid_o,
    output dma_pkg::addr_t     w_dp_addr_o,
    output dma_pkg::offs_t     w_dp_offset_o,
    output dma_pkg::offs_t     w_dp_tailer_o
);
    dma_pkg::ctrl_state_e state_q, state_d;

    // Registered transfer
    dma_pkg::addr_t src_q, dst_q;
    dma_pkg::len_t  len_q;

    // Derived beat geometry
    dma_pkg::offs_t src_off, dst_off, src_tail, dst_tail;
    dma_pkg::len_t  rd_words, wr_words;
    logic [`DMA_LEN_WIDTH:0] rd_span, wr_span;

    // Beat counters: read address, read datapath, write datapath, completions
    dma_pkg::len_t rd_cnt_q, rdp_cnt_q, wdp_cnt_q, wr_cnt_q;

    logic start_ok;
    logic last_write;
    logic err_q;

    // ----------------------------------------------------------------------
    // Transfer geometry
    // ----------------------------------------------------------------------
    assign src_off  = src_q[`DMA_OFFS_WIDTH-1:0];
    assign dst_off  = dst_q[`DMA_OFFS_WIDTH-1:0];
    // Lane just above the last byte, wraps to zero on a full last word
    assign src_tail = src_off + len_q[`DMA_OFFS_WIDTH-1:0];
    assign dst_tail = dst_off + len_q[`DMA_OFFS_WIDTH-1:0];

    // Offset of the last byte counted from the first word
    assign rd_span = {1'b0, len_q} + src_off - 1'b1;
    assign wr_span = {1'b0, len_q} + dst_off - 1'b1;

    // Words touched, zero for an empty transfer
    assign rd_words = (len_q == '0) ? '0 : dma_pkg::len_t'(rd_span >> `DMA_OFFS_WIDTH) + 1'b1;
    assign wr_words = (len_q == '0) ? '0 : dma_pkg::len_t'(wr_span >> `DMA_OFFS_WIDTH) + 1'b1;

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    assign busy_o   = (state_q == dma_pkg::CTRL_RUN);
    assign done_o   = (state_q == dma_pkg::CTRL_DONE);
    assign start_ok = start_i & ~busy_o;

    // Finished once every write response is back
    assign last_write = (wr_words == '0) |
                        (wr_beat_done_i & (wr_cnt_q == wr_words - 1'b1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::CTRL_RUN: begin
                if (last_write) begin
                    state_d = dma_pkg::CTRL_DONE;
                end
            end
            default: begin
                // Idle and done both take a new start
                state_d = start_ok ? dma_pkg::CTRL_RUN : dma_pkg::CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= dma_pkg::CTRL_IDLE;
            rd_cnt_q  <= '0;
            rdp_cnt_q <= '0;
            wdp_cnt_q <= '0;
            wr_cnt_q  <= '0;
            err_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_ok) begin
                rd_cnt_q  <= '0;
                rdp_cnt_q <= '0;
                wdp_cnt_q <= '0;
                wr_cnt_q  <= '0;
                err_q     <= 1'b0;
            end else begin
                if (rd_req_o && rd_gnt_i) rd_cnt_q <= rd_cnt_q + 1'b1;
                if (r_dp_ready_i) rdp_cnt_q <= rdp_cnt_q + 1'b1;
                if (w_dp_ready_i) wdp_cnt_q <= wdp_cnt_q + 1'b1;
                if (wr_beat_done_i) wr_cnt_q <= wr_cnt_q + 1'b1;
                // Sticky until the next accepted start
                if (rd_err_seen_i || wr_err_seen_i) err_q <= 1'b1;
            end
        end
    end

    // Transfer payload
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            len_q <= length_i;
        end
    end

    assign err_o = err_q;

    // ----------------------------------------------------------------------
    // Beat streams
    // ----------------------------------------------------------------------
    // Read addresses walk word by word from the aligned source start
    assign rd_req_o  = busy_o & (rd_cnt_q < rd_words);
    assign rd_addr_o = {src_q[`DMA_ADDR_WIDTH-1:`DMA_OFFS_WIDTH], `DMA_OFFS_WIDTH'(0)}
                     + (dma_pkg::addr_t'(rd_cnt_q) << `DMA_OFFS_WIDTH);

    // Read datapath, offset on first beat, tailer on last
    assign r_dp_valid_o  = busy_o & (rdp_cnt_q < rd_words);
    assign r_dp_offset_o = (rdp_cnt_q == '0) ? src_off : '0;
    assign r_dp_tailer_o = (rdp_cnt_q == rd_words - 1'b1) ? src_tail : '0;
    assign r_dp_shift_o  = dst_off - src_off;

    // Write datapath from the destination side
    assign w_dp_valid_o  = busy_o & (wdp_cnt_q < wr_words);
    assign w_dp_addr_o   = {dst_q[`DMA_ADDR_WIDTH-1:`DMA_OFFS_WIDTH], `DMA_OFFS_WIDTH'(0)}
                         + (dma_pkg::addr_t'(wdp_cnt_q) << `DMA_OFFS_WIDTH);
    assign w_dp_offset_o = (wdp_cnt_q == '0) ? dst_off : '0;
    assign w_dp_tailer_o = (wdp_cnt_q == wr_words - 1'b1) ? dst_tail : '0;

endmodule

//--- design/dma_obi_read.sv
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_obi_read (
    input  logic           r_dp_valid_i,
    input  dma_pkg::offs_t r_dp_offset_i,
    input  dma_pkg::offs_t r_dp_tailer_i,
    input  dma_pkg::offs_t r_dp_shift_i,
    input  logic           rd_rvalid_i,
    input  dma_pkg::data_t rd_rdata_i,
    input  logic           rd_err_i,
    input  dma_pkg::strb_t lane_full_i,
    output logic           r_dp_ready_o,
    output logic           rd_rready_o,
    output dma_pkg::strb_t lane_push_o,
    output dma_pkg::data_t lane_wdata_o,
    output logic           rd_err_seen_o
);
    // Mask in source lane order, before the shift
    dma_pkg::strb_t mask_rd;
    // Mask in destination lane order
    dma_pkg::strb_t mask_in;

    // Double-width copies for the rotation
    logic [2*`DMA_STRB_WIDTH-1:0] mask_dbl;
    logic [2*`DMA_DATA_WIDTH-1:0] data_dbl;

    logic in_ready;
    logic take;

    // ----------------------------------------------------------------------
    // Mask pre-calculation
    // ----------------------------------------------------------------------
    // Unaligned ends carry unwanted bytes
    // e.g. 7 bytes from offset 2: iivv|vvvv|viii
    assign mask_rd = dma_pkg::lane_mask(r_dp_offset_i, r_dp_tailer_i);

    // ----------------------------------------------------------------------
    // Barrel shifter
    // ----------------------------------------------------------------------
    // Rotate left by the shift, bytes wrap into the low lanes
    assign mask_dbl     = {mask_rd, mask_rd} << r_dp_shift_i;
    assign mask_in      = mask_dbl[2*`DMA_STRB_WIDTH-1:`DMA_STRB_WIDTH];
    assign data_dbl     = {rd_rdata_i, rd_rdata_i} << {r_dp_shift_i, 3'b000};
    assign lane_wdata_o = data_dbl[2*`DMA_DATA_WIDTH-1:`DMA_DATA_WIDTH];

    // ----------------------------------------------------------------------
    // Read control
    // ----------------------------------------------------------------------
    // Room needed only in the lanes this beat writes
    assign in_ready = &(~lane_full_i | ~mask_in);

    // Response taken only against a live descriptor
    assign rd_rready_o = r_dp_valid_i & in_ready;
    assign take        = rd_rvalid_i & rd_rready_o;

    // Push the selected lanes in the same cycle
    assign lane_push_o = take ? mask_in : '0;

    // One descriptor per response beat
    assign r_dp_ready_o = take;

    // Errored beats still flow so the write side drains
    assign rd_err_seen_o = take & rd_err_i;

endmodule

//--- design/dma_lane_buffer.sv
`timescale 1ns/1ns
`include "dma_settings.svh"

module dma_lane_buffer (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  dma_pkg::strb_t lane_push_i,
    input  dma_pkg::data_t lane_wdata_i,
    input  dma_pkg::strb_t lane_pop_i,
    output dma_pkg::strb_t lane_full_o,
    output dma_pkg::strb_t lane_empty_o,
    output dma_pkg::data_t lane_rdata_o
);
    localparam int PtrWidth = $clog2(`DMA_LANE_DEPTH);

    // One independent byte FIFO per lane
    // Lanes fill and drain out of step during realignment
    for (genvar l = 0; l < `DMA_STRB_WIDTH; l++) begin : gen_lane
        dma_pkg::byte_t mem [`DMA_LANE_DEPTH];

        logic [PtrWidth-1:0] wptr_q, rptr_q;
        logic [PtrWidth:0]   cnt_q;

        logic push, pop;

        assign push = lane_push_i[l];
        assign pop  = lane_pop_i[l];

        // Pointers and fill level
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wptr_q <= '0;
                rptr_q <= '0;
                cnt_q  <= '0;
            end else begin
                if (push) wptr_q <= wptr_q + 1'b1;
                if (pop) rptr_q <= rptr_q + 1'b1;
                case ({push, pop})
                    2'b10:   cnt_q <= cnt_q + 1'b1;
                    2'b01:   cnt_q <= cnt_q - 1'b1;
                    default: cnt_q <= cnt_q;
                endcase
            end
        end

        // Storage, visible at the head one cycle after the push
        always_ff @(posedge clk_i) begin
            if (push) begin
                mem[wptr_q] <= lane_wdata_i[8*l +: 8];
            end
        end

        assign lane_full_o[l]        = (cnt_q == (PtrWidth+1)'(`DMA_LANE_DEPTH));
        assign lane_empty_o[l]       = (cnt_q == '0);
        assign lane_rdata_o[8*l +: 8] = mem[rptr_q];
    end

endmodule

//--- design/dma_obi_write.sv
`timescale 1ns/1ns

module dma_obi_write (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           w_dp_valid_i,
    input  dma_pkg::addr_t w_dp_addr_i,
    input  dma_pkg::offs_t w_dp_offset_i,
    input  dma_pkg::offs_t w_dp_tailer_i,
    input  dma_pkg::strb_t lane_empty_i,
    input  dma_pkg::data_t lane_rdata_i,
    input  logic           wr_gnt_i,
    input  logic           wr_rvalid_i,
    input  logic           wr_err_i,
    output logic           w_dp_ready_o,
    output dma_pkg::strb_t lane_pop_o,
    output logic           wr_req_o,
    output dma_pkg::addr_t wr_addr_o,
    output dma_pkg::data_t wr_wdata_o,
    output dma_pkg::strb_t wr_be_o,
    output logic           wr_rready_o,
    output logic           wr_beat_done_o,
    output logic           wr_err_seen_o
);
    // Destination-aligned byte enables
    dma_pkg::strb_t be;
    // A write is waiting for its response
    logic outst_q;
    logic lanes_ok;
    logic granted;

    // ----------------------------------------------------------------------
    // Address phase
    // ----------------------------------------------------------------------
    assign be = dma_pkg::lane_mask(w_dp_offset_i, w_dp_tailer_i);

    // All enabled lanes hold a byte
    assign lanes_ok = &(~lane_empty_i | ~be);

    // Lanes and descriptor stay put until the grant
    assign wr_req_o   = w_dp_valid_i & ~outst_q & lanes_ok;
    assign wr_addr_o  = w_dp_addr_i;
    assign wr_wdata_o = lane_rdata_i;
    assign wr_be_o    = be;
    assign granted    = wr_req_o & wr_gnt_i;

    // Lane heads popped in the grant cycle
    assign lane_pop_o   = granted ? be : '0;
    assign w_dp_ready_o = granted;

    // ----------------------------------------------------------------------
    // Response phase
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outst_q <= 1'b0;
        end else if (granted) begin
            outst_q <= 1'b1;
        end else if (wr_beat_done_o) begin
            outst_q <= 1'b0;
        end
    end

    // Ready only for the single outstanding write
    assign wr_rready_o    = outst_q;
    assign wr_beat_done_o = wr_rvalid_i & outst_q;
    assign wr_err_seen_o  = wr_beat_done_o & wr_err_i;

endmodule

//--- design/dma_backend_top.sv
`timescale 1ns/1ns

module dma_backend_top (
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Transfer port
    input  logic           start_i,
    input  dma_pkg::addr_t src_addr_i,
    input  dma_pkg::addr_t dst_addr_i,
    input  dma_pkg::len_t  length_i,
    output logic           busy_o,
    output logic           done_o,
    output logic           err_o,
    // OBI read manager
    output logic           rd_req_o,
    output dma_pkg::addr_t rd_addr_o,
    input  logic           rd_gnt_i,
    input  logic           rd_rvalid_i,
    input  dma_pkg::data_t rd_rdata_i,
    input  logic           rd_err_i,
    output logic           rd_rready_o,
    // OBI write manager
    output logic           wr_req_o,
    output dma_pkg::addr_t wr_addr_o,
    output dma_pkg::data_t wr_wdata_o,
    output dma_pkg::strb_t wr_be_o,
    input  logic           wr_gnt_i,
    input  logic           wr_rvalid_i,
    input  logic           wr_err_i,
    output logic           wr_rready_o
);
    // Read datapath descriptor
    logic           r_dp_valid, r_dp_ready;
    dma_pkg::offs_t r_dp_offset, r_dp_tailer, r_dp_shift;

    // Write datapath descriptor
    logic           w_dp_valid, w_dp_ready;
    dma_pkg::addr_t w_dp_addr;
    dma_pkg::offs_t w_dp_offset, w_dp_tailer;

    // Byte-lane buffer
    dma_pkg::strb_t lane_push, lane_pop, lane_full, lane_empty;
    dma_pkg::data_t lane_wdata, lane_rdata;

    // Completion and errors
    logic wr_beat_done, rd_err_seen, wr_err_seen;

    dma_transfer_ctrl u_ctrl (
        .clk_i, .rst_n_i, .start_i, .src_addr_i, .dst_addr_i, .length_i,
        .rd_gnt_i,
        .r_dp_ready_i   (r_dp_ready),
        .w_dp_ready_i   (w_dp_ready),
        .wr_beat_done_i (wr_beat_done),
        .rd_err_seen_i  (rd_err_seen),
        .wr_err_seen_i  (wr_err_seen),
        .busy_o, .done_o, .err_o, .rd_req_o, .rd_addr_o,
        .r_dp_valid_o   (r_dp_valid),
        .r_dp_offset_o  (r_dp_offset),
        .r_dp_tailer_o  (r_dp_tailer),
        .r_dp_shift_o   (r_dp_shift),
        .w_dp_valid_o   (w_dp_valid),
        .w_dp_addr_o    (w_dp_addr),
        .w_dp_offset_o  (w_dp_offset),
        .w_dp_tailer_o  (w_dp_tailer)
    );

    dma_obi_read u_read (
        .r_dp_valid_i  (r_dp_valid),
        .r_dp_offset_i (r_dp_offset),
        .r_dp_tailer_i (r_dp_tailer),
        .r_dp_shift_i  (r_dp_shift),
        .rd_rvalid_i, .rd_rdata_i, .rd_err_i,
        .lane_full_i   (lane_full),
        .r_dp_ready_o  (r_dp_ready),
        .rd_rready_o,
        .lane_push_o   (lane_push),
        .lane_wdata_o  (lane_wdata),
        .rd_err_seen_o (rd_err_seen)
    );

    dma_lane_buffer u_buffer (
        .clk_i, .rst_n_i,
        .lane_push_i  (lane_push),
        .lane_wdata_i (lane_wdata),
        .lane_pop_i   (lane_pop),
        .lane_full_o  (lane_full),
        .lane_empty_o (lane_empty),
        .lane_rdata_o (lane_rdata)
    );

    dma_obi_write u_write (
        .clk_i, .rst_n_i,
        .w_dp_valid_i   (w_dp_valid),
        .w_dp_addr_i    (w_dp_addr),
        .w_dp_offset_i  (w_dp_offset),
        .w_dp_tailer_i  (w_dp_tailer),
        .lane_empty_i   (lane_empty),
        .lane_rdata_i   (lane_rdata),
        .wr_gnt_i, .wr_rvalid_i, .wr_err_i,
        .w_dp_ready_o   (w_dp_ready),
        .lane_pop_o     (lane_pop),
        .wr_req_o, .wr_addr_o, .wr_wdata_o, .wr_be_o, .wr_rready_o,
        .wr_beat_done_o (wr_beat_done),
        .wr_err_seen_o  (wr_err_seen)
    );

endmodule

//--- verification/dma_obi_mem.sv
`timescale 1ns/1ns

module dma_obi_mem (
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Grant enables from the testbench LFSR
    input  logic           rd_allow_i,
    input  logic           wr_allow_i,
    // Byte load port used to preset the window
    input  logic           ld_en_i,
    input  logic [7:0]     ld_addr_i,
    input  dma_pkg::byte_t ld_data_i,
    // OBI read subordinate
    input  logic           rd_req_i,
    input  dma_pkg::addr_t rd_addr_i,
    output logic           rd_gnt_o,
    output logic           rd_rvalid_o,
    output dma_pkg::data_t rd_rdata_o,
    output logic           rd_err_o,
    input  logic           rd_rready_i,
    // OBI write subordinate
    input  logic           wr_req_i,
    input  dma_pkg::addr_t wr_addr_i,
    input  dma_pkg::data_t wr_wdata_i,
    input  dma_pkg::strb_t wr_be_i,
    output logic           wr_gnt_o,
    output logic           wr_rvalid_o,
    output logic           wr_err_o,
    input  logic           wr_rready_i
);
    // 256-byte window
    dma_pkg::byte_t mem [256];

    // One response in flight per port, the grant waits for it to drain
    assign rd_gnt_o = rd_req_i & rd_allow_i & ~rd_rvalid_o;
    assign wr_gnt_o = wr_req_i & wr_allow_i & ~wr_rvalid_o;

    // ----------------------------------------------------------------------
    // Response registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        logic [7:0] base;
        if (!rst_n_i) begin
            rd_rvalid_o <= 1'b0;
            rd_rdata_o  <= '0;
            rd_err_o    <= 1'b0;
            wr_rvalid_o <= 1'b0;
            wr_err_o    <= 1'b0;
        end else begin
            base = {rd_addr_i[7:2], 2'b00};
            if (rd_gnt_o) begin
                rd_rvalid_o <= 1'b1;
                rd_err_o    <= rd_addr_i[31];
                // Errored reads return zero data
                if (rd_addr_i[31]) begin
                    rd_rdata_o <= '0;
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        rd_rdata_o[8*k +: 8] <= mem[base + 8'(k)];
                    end
                end
            end else if (rd_rvalid_o && rd_rready_i) begin
                rd_rvalid_o <= 1'b0;
            end
            if (wr_gnt_o) begin
                wr_rvalid_o <= 1'b1;
                wr_err_o    <= wr_addr_i[31];
            end else if (wr_rvalid_o && wr_rready_i) begin
                wr_rvalid_o <= 1'b0;
            end
        end
    end

    // Storage, written by the load port or a granted write
    always_ff @(posedge clk_i) begin
        logic [7:0] wbase;
        wbase = {wr_addr_i[7:2], 2'b00};
        if (ld_en_i) begin
            mem[ld_addr_i] <= ld_data_i;
        end
        if (wr_gnt_o && !wr_addr_i[31]) begin
            for (int k = 0; k < 4; k++) begin
                if (wr_be_i[k]) mem[wbase + 8'(k)] <= wr_wdata_i[8*k +: 8];
            end
        end
    end

endmodule

//--- verification/dma_backend_assert.sv
`timescale 1ns/1ns

module dma_backend_assert (
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           rd_req_o,
    input dma_pkg::addr_t rd_addr_o,
    input logic           rd_gnt_i,
    input logic           wr_req_o,
    input dma_pkg::addr_t wr_addr_o,
    input logic           wr_gnt_i,
    input logic           busy_o,
    input logic           done_o
);
    // OBI address phase holds until granted
    a_rd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o))
        else $error("read request dropped or address changed before grant");

    a_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_req_o && !wr_gnt_i |=> wr_req_o && $stable(wr_addr_o))
        else $error("write request dropped or address changed before grant");

    // Completion pulse closes the busy window
    // Busy must have been high just before and is low during done
    a_busy_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> !busy_o && $past(busy_o))
        else $error("done without a preceding busy window or busy during done");

endmodule

bind dma_backend_top dma_backend_assert u_assert (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rd_req_o (rd_req_o),
    .rd_addr_o(rd_addr_o),
    .rd_gnt_i (rd_gnt_i),
    .wr_req_o (wr_req_o),
    .wr_addr_o(wr_addr_o),
    .wr_gnt_i (wr_gnt_i),
    .busy_o   (busy_o),
    .done_o   (done_o)
);

//--- verification/dma_backend_tb.sv
`timescale 1ns/1ns

module dma_backend_tb;

    // Bytes moved over all tests with a generous per-byte cycle budget
    localparam int TOTAL_BYTES = 16 + 720 + 16 + 320 + 8 + 16;
    localparam int CYCLE_LIMIT = 300 * TOTAL_BYTES + 5000;

    logic clk_i, rst_n_i;
    logic start_i;
    dma_pkg::addr_t src_addr_i, dst_addr_i;
    dma_pkg::len_t  length_i;
    logic busy_o, done_o, err_o;

    logic rd_req, rd_gnt, rd_rvalid, rd_err, rd_rready;
    logic wr_req, wr_gnt, wr_rvalid, wr_err, wr_rready;
    dma_pkg::addr_t rd_addr, wr_addr;
    dma_pkg::data_t rd_rdata, wr_wdata;
    dma_pkg::strb_t wr_be;

    logic rd_allow, wr_allow, throttle;
    logic ld_en;
    logic [7:0] ld_addr;
    dma_pkg::byte_t ld_data;

    dma_pkg::byte_t model [256];
    dma_pkg::strb_t be_log [$];
    logic [31:0] lfsr;
    int mismatch_cnt, fail_cnt, done_cnt, cycle_cnt;

    dma_backend_top DUT (
        .clk_i, .rst_n_i, .start_i, .src_addr_i, .dst_addr_i, .length_i,
        .busy_o, .done_o, .err_o,
        .rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_gnt_i(rd_gnt),
        .rd_rvalid_i(rd_rvalid), .rd_rdata_i(rd_rdata), .rd_err_i(rd_err),
        .rd_rready_o(rd_rready),
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_wdata_o(wr_wdata), .wr_be_o(wr_be),
        .wr_gnt_i(wr_gnt), .wr_rvalid_i(wr_rvalid), .wr_err_i(wr_err),
        .wr_rready_o(wr_rready)
    );

    dma_obi_mem u_mem (
        .clk_i, .rst_n_i, .rd_allow_i(rd_allow), .wr_allow_i(wr_allow),
        .ld_en_i(ld_en), .ld_addr_i(ld_addr), .ld_data_i(ld_data),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt), .rd_rvalid_o(rd_rvalid),
        .rd_rdata_o(rd_rdata), .rd_err_o(rd_err), .rd_rready_i(rd_rready),
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_wdata_i(wr_wdata), .wr_be_i(wr_be),
        .wr_gnt_o(wr_gnt), .wr_rvalid_o(wr_rvalid), .wr_err_o(wr_err), .wr_rready_i(wr_rready)
    );

    // ----------------------------------------------------------------------
    // Random source
    // ----------------------------------------------------------------------
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], take_bit()};
        return v;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Grants gated per cycle
    // Throttled mode grants about one cycle in eight
    always @(posedge clk_i) begin
        rd_allow <= throttle ? (take_bit() & take_bit() & take_bit()) : take_bit();
        wr_allow <= throttle ? (take_bit() & take_bit() & take_bit()) : take_bit();
    end

    // Done pulses and granted byte enables
    always @(negedge clk_i) begin
        if (done_o) done_cnt++;
        if (wr_req && wr_gnt) be_log.push_back(wr_be);
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            fail_cnt++;
            $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_byte(input dma_pkg::byte_t got, input dma_pkg::byte_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %b exp %b", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input dma_pkg::strb_t got, input dma_pkg::strb_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, what, got, exp);
        end
    endtask

    // Whole window against the model
    // Covers the bytes around each range
    task automatic scan_window(input string what);
        for (int i = 0; i < 256; i++) begin
            check_byte(u_mem.mem[i], model[i], $sformatf("%s byte %0d", what, i));
        end
    endtask

    task automatic fill_memory();
        // LFSR byte mixed with the address of each location
        for (int i = 0; i < 256; i++) begin
            model[i] = dma_pkg::byte_t'(rand_bits(8)) ^ 8'(i);
        end
        // One byte per cycle through the load port
        for (int i = 0; i < 256; i++) begin
            @(posedge clk_i);
            ld_en   <= 1'b1;
            ld_addr <= 8'(i);
            ld_data <= model[i];
        end
        @(posedge clk_i);
        ld_en <= 1'b0;
    endtask

    // Start pulse and optional second start while busy
    // Then wait for done
    task automatic run_copy(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                            input dma_pkg::len_t len, input logic extra_start,
                            output logic err);
        @(posedge clk_i);
        start_i    <= 1'b1;
        src_addr_i <= src;
        dst_addr_i <= dst;
        length_i   <= len;
        @(posedge clk_i);
        if (extra_start) begin
            // Lands in the first busy cycle
            src_addr_i <= 32'h0000_0040;
            dst_addr_i <= 32'h0000_00f0;
            length_i   <= 16'd7;
            @(posedge clk_i);
        end
        start_i <= 1'b0;
        do @(negedge clk_i); while (done_o !== 1'b1);
        err = err_o;
    endtask

    task automatic copy_and_check(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                                  input dma_pkg::len_t len, input logic extra_start,
                                  input logic exp_err, input string what);
        logic err;
        int base;
        base = done_cnt;
        run_copy(src, dst, len, extra_start, err);
        // Errored reads deliver zero bytes
        for (int i = 0; i < int'(len); i++) begin
            model[8'(dst) + 8'(i)] = exp_err ? 8'h00 : model[8'(src) + 8'(i)];
        end
        repeat (3) @(negedge clk_i);
        check_flag(err, exp_err, {what, " err_o"});
        check_flag(done_cnt - base == 1, 1'b1, {what, " single done"});
        scan_window(what);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic reset_outputs();
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "reset busy_o");
        check_flag(done_o, 1'b0, "reset done_o");
        check_flag(err_o, 1'b0, "reset err_o");
        check_flag(rd_req, 1'b0, "reset rd_req_o");
        check_flag(rd_rready, 1'b0, "reset rd_rready_o");
        check_flag(wr_req, 1'b0, "reset wr_req_o");
        check_flag(wr_rready, 1'b0, "reset wr_rready_o");
    endtask

    task automatic aligned_copy();
        be_log.delete();
        copy_and_check(32'h0000_0010, 32'h0000_0090, 16'd16, 1'b0, 1'b0, "aligned");
        check_flag(be_log.size() == 4, 1'b1, "aligned write count");
        foreach (be_log[i]) check_strb(be_log[i], 4'hf, "aligned byte enable");
    endtask

    task automatic unaligned_copies();
        for (int so = 0; so < 4; so++) begin
            for (int d = 0; d < 4; d++) begin
                for (int len = 1; len <= 9; len++) begin
                    copy_and_check(32'(16 + so), 32'(160 + d), 16'(len), 1'b0, 1'b0,
                                   $sformatf("unaligned s%0d d%0d l%0d", so, d, len));
                end
            end
        end
    endtask

    task automatic zero_and_ignored();
        copy_and_check(32'h0000_0020, 32'h0000_00a0, 16'd0, 1'b0, 1'b0, "zero length");
        copy_and_check(32'h0000_0005, 32'h0000_00b2, 16'd16, 1'b1, 1'b0, "ignored start");
    endtask

    task automatic throttled_copies();
        throttle <= 1'b1;
        for (int n = 0; n < 20; n++) begin
            copy_and_check(32'(8 + rand_bits(5)), 32'(136 + rand_bits(5)),
                           16'(1 + rand_bits(4)), 1'b0, 1'b0,
                           $sformatf("backpressure %0d", n));
        end
        throttle <= 1'b0;
    endtask

    task automatic error_copies();
        copy_and_check(32'h8000_0011, 32'h0000_00c0, 16'd8, 1'b0, 1'b1, "read error");
        copy_and_check(32'h0000_0003, 32'h0000_00c5, 16'd16, 1'b0, 1'b0, "after error");
    endtask

    initial begin
        lfsr         = 32'hd0d9_78a8;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        done_cnt     = 0;
        cycle_cnt    = 0;
        rst_n_i      = 1'b0;
        start_i      = 1'b0;
        src_addr_i   = '0;
        dst_addr_i   = '0;
        length_i     = '0;
        rd_allow     = 1'b0;
        wr_allow     = 1'b0;
        throttle     = 1'b0;
        ld_en        = 1'b0;
        ld_addr      = '0;
        ld_data      = '0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        reset_outputs();
        fill_memory();
        aligned_copy();
        unaligned_copies();
        zero_and_ignored();
        throttled_copies();
        error_copies();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+design
design/dma_pkg.sv
design/dma_transfer_ctrl.sv
design/dma_obi_read.sv
design/dma_lane_buffer.sv
design/dma_obi_write.sv
design/dma_backend_top.sv
verification/dma_obi_mem.sv
verification/dma_backend_assert.sv
verification/dma_backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module dma_backend_tb -f filelist.f \
    && ./obj_dir/Vdma_backend_tb | tee /dev/stderr | grep -q "Verification passed" \
    && echo "RUN PASS" \
    || { echo "RUN FAIL"; exit 1; }
